//--- hdl/z80_io_config.svh
// build-time sizes and port base of the Z80 I/O write path, included by RTL and testbench
`ifndef Z80_IO_CONFIG_SVH
`define Z80_IO_CONFIG_SVH

// ****************************************
// CPU bus
// ****************************************

// width of the Z80 I/O port address as seen by the register bank
`define Z80_IO_ADDR_WIDTH 8

// ****************************************
// clock crossing
// ****************************************

// stretch counter width, the stretched level lasts 2**bits clk1 cycles
`define Z80_IO_STRETCH_BITS 1
// number of clk2 flops in the synchronizer chain, two or more
`define Z80_IO_SYNC_LEN 2

// ****************************************
// register bank
// ****************************************

// number of byte registers behind the decoded port window
`define Z80_IO_REG_COUNT 16
// first port address of that window
`define Z80_IO_PORT_BASE 8'h40

`endif

//--- hdl/z80_io_pkg.sv
// shared types for the Z80 I/O write path, imported by every block that carries bus values
package z80_io_pkg;

    `include "z80_io_config.svh"

    // ****************************************
    // bus payloads
    // ****************************************

    // port address driven by the CPU during an I/O cycle
    typedef logic [`Z80_IO_ADDR_WIDTH-1:0] io_addr_t;

    // one data byte on the Z80 data bus
    typedef logic [7:0] io_data_t;

    // index into the I/O register bank
    // sized from the register count so that every index is a real register
    typedef logic [$clog2(`Z80_IO_REG_COUNT)-1:0] reg_index_t;

    // ****************************************
    // bus cycle FSM
    // ****************************************

    // st_seen is the first clk1 edge with the write strobes down
    // st_tick is the single cycle that raises wr_tick1
    // st_wait_end holds off until iorq_n returns high
    typedef enum logic [1:0] {
        st_idle,
        st_seen,
        st_tick,
        st_wait_end
    } bus_state_t;

endpackage

//--- hdl/sync_stretch.sv
// carries a single clk1 tick into the clk2 domain as one clk2 tick by stretching and synchronizing it
`include "z80_io_config.svh"

module sync_stretch #(
    // the stretched level lasts 2**STRETCH_BITS clk1 cycles, at least one bit
    parameter int STRETCH_BITS = `Z80_IO_STRETCH_BITS,
    // number of clk2 synchronizer flops, at least two
    parameter int SYNC_LEN     = `Z80_IO_SYNC_LEN
) (
    input  logic reset,
    input  logic clk1,
    input  logic clk2,
    input  logic in,
    output logic out
);

    // ****************************************
    // clk1 side stretcher
    // ****************************************

    logic [STRETCH_BITS-1:0] cnt_q;
    logic                    stretch_q;

    // a tick loads the counter with all ones and raises the level
    // the level drops on the edge after the counter has run down to zero
    always_ff @(posedge clk1) begin
        if (reset) begin
            cnt_q     <= '0;
            stretch_q <= 1'b0;
        end else if (in) begin
            cnt_q     <= '1;
            stretch_q <= 1'b1;
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end else begin
            stretch_q <= 1'b0;
        end
    end

    // ****************************************
    // clk2 side synchronizer
    // ****************************************

    // stretch_q is the only signal that crosses, and it is a clean flop output
    logic [SYNC_LEN-1:0] sync_q;
    logic                last_q;

    always_ff @(posedge clk2) begin
        if (reset) begin
            sync_q <= '0;
            last_q <= 1'b0;
        end else begin
            sync_q <= {sync_q[SYNC_LEN-2:0], stretch_q};
            last_q <= sync_q[SYNC_LEN-1];
        end
    end

    // rising edge of the synchronized level gives exactly one clk2 cycle
    assign out = sync_q[SYNC_LEN-1] && !last_q;

    // ****************************************
    // rate check
    // ****************************************

    // a new tick while the level is still up would merge with the previous one
    // so the source must leave the stretcher idle between ticks
    a_no_retrigger: assert property (
        @(posedge clk1) disable iff (reset)
        in |-> !stretch_q
    ) else $error("sync_stretch retriggered while the stretched level was still high");

endmodule

//--- hdl/z80_io_cycle_fsm.sv
// clk1 bus watcher that turns each genuine Z80 I/O write cycle into a single wr_tick1 pulse
module z80_io_cycle_fsm
    import z80_io_pkg::*;
(
    input  logic clk1,
    input  logic reset,
    input  logic iorq_n,
    input  logic wr_n,
    input  logic rd_n,
    input  logic m1_n,
    output logic wr_tick1
);

    // ****************************************
    // strobe decode
    // ****************************************

    // an I/O write has iorq and wr asserted with rd idle
    // m1_n low together with iorq_n marks an interrupt acknowledge and is never a write
    logic is_io_wr;

    bus_state_t state_q;
    bus_state_t state_d;

    assign is_io_wr = !iorq_n && !wr_n && rd_n && m1_n;

    // ****************************************
    // next state
    // ****************************************

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            st_idle: begin
                // reads and interrupt acknowledges never get past here
                if (is_io_wr) begin
                    state_d = st_seen;
                end
            end
            st_seen: begin
                // the strobes must still be down one edge later
                // otherwise this was a glitch or a short strobe and no tick is given
                if (is_io_wr) begin
                    state_d = st_tick;
                end else begin
                    state_d = st_idle;
                end
            end
            st_tick: begin
                state_d = st_wait_end;
            end
            st_wait_end: begin
                // one tick per cycle, so stay here until the CPU ends the cycle
                if (iorq_n) begin
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk1) begin
        if (reset) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // the tick is a Moore output, two clk1 edges after the strobes go low
    assign wr_tick1 = (state_q == st_tick);

    // ****************************************
    // bus protocol check
    // ****************************************

    // the CPU never drives wr and rd together inside an I/O cycle
    a_no_rd_wr_overlap: assert property (
        @(posedge clk1) disable iff (reset)
        !iorq_n |-> !(!wr_n && !rd_n)
    ) else $error("wr_n and rd_n both low during an I/O cycle");

endmodule

//--- hdl/z80_wr_cdc.sv
// holds the CPU write address and data in clk1 and moves the write tick into clk2 through a stretcher
`include "z80_io_config.svh"

module z80_wr_cdc
    import z80_io_pkg::*;
(
    input  logic     reset,
    input  logic     clk1,
    input  logic     clk2,
    input  logic     wr_tick1,
    input  io_data_t din1,
    input  io_addr_t ain1,
    output logic     wr_tick2,
    output io_data_t dout2,
    output io_addr_t aout2
);

    // ****************************************
    // clk1 holding register
    // ****************************************

    // address and data are captured on the tick and kept until the next one
    // the stretcher and synchronizer delay wr_tick2 by several clk2 edges
    // so these flops are long settled when the clk2 side samples them
    io_addr_t aout_q;
    io_data_t dout_q;

    always_ff @(posedge clk1) begin
        if (wr_tick1) begin
            aout_q <= ain1;
            dout_q <= din1;
        end
    end

    assign aout2 = aout_q;
    assign dout2 = dout_q;

    // ****************************************
    // tick crossing
    // ****************************************

    // the tick enters the stretcher on the same edge that loads the holding register
    sync_stretch #(
        .STRETCH_BITS (`Z80_IO_STRETCH_BITS),
        .SYNC_LEN     (`Z80_IO_SYNC_LEN)
    ) u_sync_stretch (
        .reset (reset),
        .clk1  (clk1),
        .clk2  (clk2),
        .in    (wr_tick1),
        .out   (wr_tick2)
    );

endmodule

//--- hdl/z80_io_regs.sv
// clk2 register bank that decodes written port addresses, stores data, counts writes and reads back
`include "z80_io_config.svh"

module z80_io_regs
    import z80_io_pkg::*;
(
    input  logic       clk2,
    input  logic       reset,
    input  logic       wr_tick2,
    input  io_addr_t   aout2,
    input  io_data_t   dout2,
    input  reg_index_t rd_index,
    output io_data_t   rd_data,
    output logic [7:0] wr_count
);

    localparam io_addr_t PORT_BASE = `Z80_IO_PORT_BASE;
    localparam int       REG_COUNT = `Z80_IO_REG_COUNT;

    // ****************************************
    // port decode
    // ****************************************

    logic       in_range;
    io_addr_t   offset;
    reg_index_t wr_index;

    // the window runs from the base up to but not including base plus count
    assign in_range = (aout2 >= PORT_BASE) && (aout2 < PORT_BASE + REG_COUNT);

    // inside the window the offset always fits the index width
    assign offset   = aout2 - PORT_BASE;
    assign wr_index = reg_index_t'(offset);

    // ****************************************
    // register bank and write counter
    // ****************************************

    io_data_t   regs_q [REG_COUNT];
    logic [7:0] count_q;

    // writes outside the window still arrive as ticks but are dropped here
    always_ff @(posedge clk2) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
            count_q <= '0;
        end else if (wr_tick2 && in_range) begin
            regs_q[wr_index] <= dout2;
            // the counter wraps at 256 by design
            count_q <= count_q + 8'd1;
        end
    end

    assign wr_count = count_q;

    // readback is combinational from the index
    assign rd_data = regs_q[rd_index];

endmodule

//--- hdl/z80_io_top.sv
// top level of the Z80 I/O write path, joining the bus FSM, the clock crossing and the register bank
module z80_io_top
    import z80_io_pkg::*;
(
    input  logic       clk1,
    input  logic       clk2,
    input  logic       reset,
    // CPU side strobes and buses in the clk1 domain
    input  logic       iorq_n,
    input  logic       wr_n,
    input  logic       rd_n,
    input  logic       m1_n,
    input  io_addr_t   addr,
    input  io_data_t   din,
    // peripheral side in the clk2 domain
    input  reg_index_t rd_index,
    output logic       io_wr,
    output io_addr_t   io_addr,
    output io_data_t   io_data,
    output io_data_t   rd_data,
    output logic [7:0] wr_count
);

    // ****************************************
    // clk1 bus cycle decode
    // ****************************************

    logic wr_tick1;

    z80_io_cycle_fsm u_cycle_fsm (
        .clk1     (clk1),
        .reset    (reset),
        .iorq_n   (iorq_n),
        .wr_n     (wr_n),
        .rd_n     (rd_n),
        .m1_n     (m1_n),
        .wr_tick1 (wr_tick1)
    );

    // ****************************************
    // clk1 to clk2 crossing
    // ****************************************

    // the crossed tick and held bus values also leave the block as io_wr, io_addr and io_data
    z80_wr_cdc u_wr_cdc (
        .reset    (reset),
        .clk1     (clk1),
        .clk2     (clk2),
        .wr_tick1 (wr_tick1),
        .din1     (din),
        .ain1     (addr),
        .wr_tick2 (io_wr),
        .dout2    (io_data),
        .aout2    (io_addr)
    );

    // ****************************************
    // clk2 register bank
    // ****************************************

    z80_io_regs u_io_regs (
        .clk2     (clk2),
        .reset    (reset),
        .wr_tick2 (io_wr),
        .aout2    (io_addr),
        .dout2    (io_data),
        .rd_index (rd_index),
        .rd_data  (rd_data),
        .wr_count (wr_count)
    );

endmodule

//--- dv/z80_io_tb.sv
// self-checking testbench for the Z80 I/O write path, run from the project root with dv/z80_io_tests.txt
`include "z80_io_config.svh"

module z80_io_tb
    import z80_io_pkg::*;
();

    localparam int       VEC_DEPTH    = 64;
    localparam int       RAND_WRITES  = 12;
    localparam int       WR_TIMEOUT   = 40;
    localparam int       QUIET_CYCLES = 20;
    localparam io_addr_t PORT_BASE    = `Z80_IO_PORT_BASE;
    localparam io_addr_t WINDOW       = io_addr_t'(`Z80_IO_REG_COUNT);

    logic       clk1 = 1'b0;
    logic       clk2 = 1'b0;
    logic       reset;
    logic       iorq_n;
    logic       wr_n;
    logic       rd_n;
    logic       m1_n;
    io_addr_t   addr;
    io_data_t   din;
    reg_index_t rd_index;
    logic       io_wr;
    io_addr_t   io_addr;
    io_data_t   io_data;
    io_data_t   rd_data;
    logic [7:0] wr_count;

    // each vector packs kind, io_wr flag, update flag, address and data into one word
    logic [31:0] vectors [VEC_DEPTH];
    io_data_t    model_regs [`Z80_IO_REG_COUNT];
    logic [7:0]  model_count;
    io_addr_t    exp_addr_q [$];
    io_data_t    exp_data_q [$];
    io_addr_t    obs_addr_q [$];
    io_data_t    obs_data_q [$];
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          errors_at_start = 0;
    int          seed = 32'h6359;

    // the two clocks are unrelated and clk2 runs faster so the peripheral side keeps up
    always #10 clk1 = ~clk1;
    always #7 clk2 = ~clk2;

    z80_io_top u_z80_io_top (
        .clk1(clk1), .clk2(clk2), .reset(reset),
        .iorq_n(iorq_n), .wr_n(wr_n), .rd_n(rd_n), .m1_n(m1_n), .addr(addr), .din(din),
        .rd_index(rd_index), .io_wr(io_wr), .io_addr(io_addr), .io_data(io_data),
        .rd_data(rd_data), .wr_count(wr_count)
    );

    // ****************************************
    // io_wr monitor
    // ****************************************

    // io_wr moves on rising clk2, so the falling edge sees it and the held bus settled
    always @(negedge clk2) begin
        if (!reset && io_wr) begin
            obs_addr_q.push_back(io_addr);
            obs_data_q.push_back(io_data);
        end
    end

    task automatic compare_byte(input string name, input logic [7:0] got,
                                input logic [7:0] expected);
        checks++;
        assert (got === expected) else begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("Failure at %0t: %s", $time, what);
        errors++;
    endtask

    function automatic logic in_window(input io_addr_t a);
        return (a >= PORT_BASE) && (io_addr_t'(a - PORT_BASE) < WINDOW);
    endfunction

    function automatic string kind_name(input logic [3:0] kind);
        case (kind)
            4'd1: return "write";
            4'd2: return "read";
            4'd3: return "int_ack";
            4'd4: return "short";
            default: return "write_chained";
        endcase
    endfunction

    // ****************************************
    // bus cycle driver
    // ****************************************

    task automatic release_strobes();
        iorq_n = 1'b1;
        wr_n   = 1'b1;
        rd_n   = 1'b1;
        m1_n   = 1'b1;
    endtask

    // T1 sets address and data, T2 drops the strobes, which stay low for three cycles
    // and are raised again by the T1 of the next cycle, four clk1 cycles in all
    task automatic drive_cycle(input logic [3:0] kind, input io_addr_t a, input io_data_t d);
        @(negedge clk1);
        addr = a;
        din  = d;
        release_strobes();
        @(negedge clk1);
        iorq_n = 1'b0;
        wr_n   = !((kind == 4'd1) || (kind == 4'd4) || (kind == 4'd5));
        rd_n   = !(kind == 4'd2);
        // an interrupt acknowledge has m1_n low together with iorq_n
        m1_n   = !(kind == 4'd3);
        if (kind == 4'd4) begin
            // short strobe is gone before the second clk1 edge
            @(negedge clk1);
            release_strobes();
        end else begin
            repeat (2) @(negedge clk1);
        end
    endtask

    task automatic expect_write(input logic wr, input logic upd, input io_addr_t a,
                                input io_data_t d);
        if (wr) begin
            exp_addr_q.push_back(a);
            exp_data_q.push_back(d);
        end
        if (upd) begin
            model_regs[reg_index_t'(a - PORT_BASE)] = d;
            model_count = model_count + 8'd1;
        end
    endtask

    // ****************************************
    // settling and checking
    // ****************************************

    // waits for every expected io_wr, then watches a quiet window for extra ones
    task automatic wait_for_writes();
        int cycles;
        cycles = 0;
        while (obs_addr_q.size() < exp_addr_q.size() && cycles < WR_TIMEOUT) begin
            @(posedge clk2);
            cycles++;
        end
        assert (obs_addr_q.size() >= exp_addr_q.size()) else
            report_failure("timed out waiting for io_wr");
        cycles = 0;
        while (obs_addr_q.size() <= exp_addr_q.size() && cycles < QUIET_CYCLES) begin
            @(posedge clk2);
            cycles++;
        end
        assert (obs_addr_q.size() <= exp_addr_q.size()) else
            report_failure("io_wr pulsed although no further write was driven");
        // chained writes must come out one by one in the order they were issued
        while (exp_addr_q.size() > 0 && obs_addr_q.size() > 0) begin
            compare_byte("io_addr", obs_addr_q.pop_front(), exp_addr_q.pop_front());
            compare_byte("io_data", obs_data_q.pop_front(), exp_data_q.pop_front());
        end
        exp_addr_q.delete();
        exp_data_q.delete();
        obs_addr_q.delete();
        obs_data_q.delete();
    endtask

    // sweeps the whole bank through rd_index, so stray writes show up too
    task automatic check_state();
        for (int i = 0; i < `Z80_IO_REG_COUNT; i++) begin
            @(negedge clk1);
            rd_index = reg_index_t'(i);
            @(posedge clk2);
            @(negedge clk2);
            if (i == 0) begin
                compare_byte("wr_count", wr_count, model_count);
            end
            compare_byte($sformatf("rd_data[%0d]", i), rd_data, model_regs[i]);
        end
    endtask

    task automatic settle_and_check();
        @(negedge clk1);
        release_strobes();
        wait_for_writes();
        check_state();
    endtask

    task automatic finish_test(input string what, input io_addr_t a, input io_data_t d);
        tests++;
        $display("test %0d %s addr %h data %h: %s", tests, what, a, d,
                 (errors == errors_at_start) ? "ok" : "failed");
        errors_at_start = errors;
    endtask

    task automatic run_vector(input logic [31:0] vec);
        logic [3:0] kind;
        io_addr_t   a;
        io_data_t   d;
        kind = vec[31:28];
        a    = vec[15:8];
        d    = vec[7:0];
        drive_cycle(kind, a, d);
        expect_write(vec[24], vec[20], a, d);
        // a chained write is checked together with the cycles that follow it
        if (kind != 4'd5) begin
            settle_and_check();
        end
        finish_test(kind_name(kind), a, d);
    endtask

    // ****************************************
    // main sequence
    // ****************************************

    initial begin
        logic [31:0] r;
        int          idx;
        int          cycles;
        io_addr_t    a;
        logic [3:0]  kind;
        reset    = 1'b1;
        addr     = '0;
        din      = '0;
        rd_index = '0;
        release_strobes();
        model_count = 8'h00;
        for (int i = 0; i < `Z80_IO_REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < VEC_DEPTH; i++) begin
            vectors[i] = '0;
        end
        $readmemh("dv/z80_io_tests.txt", vectors);
        repeat (2) @(negedge clk1);
        reset = 1'b0;
        // both domains must have seen the reset before the bank can be trusted
        cycles = 0;
        while (wr_count !== 8'h00 && cycles < WR_TIMEOUT) begin
            @(posedge clk2);
            cycles++;
        end
        assert (wr_count === 8'h00) else report_failure("wr_count never cleared after reset");
        assert (io_wr === 1'b0) else report_failure("io_wr high right after reset");
        check_state();
        finish_test("reset", 8'h00, 8'h00);
        idx = 0;
        while (idx < VEC_DEPTH && vectors[idx][31:28] != 4'd0) begin
            run_vector(vectors[idx]);
            idx++;
        end
        // random writes land about half inside the decoded window and are mostly chained
        for (int j = 0; j < RAND_WRITES; j++) begin
            r = $random(seed);
            a = r[0] ? PORT_BASE + io_addr_t'(r[11:8]) : r[15:8];
            kind = (r[1] && j != RAND_WRITES - 1) ? 4'd5 : 4'd1;
            run_vector({kind, 3'b000, 1'b1, 3'b000, in_window(a), 4'h0, a, r[23:16]});
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- dv/z80_io_tests.txt
// columns in hex: kind _ io_wr expected _ register update expected _ 0 _ port address _ data
// kind 1 write, 2 read, 3 interrupt acknowledge, 4 short strobe, 5 write chained, 0 ends
// writes inside the window from 40 to 4f
1_1_1_0_40_a5
1_1_1_0_4f_3c
1_1_1_0_47_81
1_1_1_0_40_5a
// writes just outside and far outside the window
1_1_0_0_3f_11
1_1_0_0_50_22
1_1_0_0_00_ff
1_1_0_0_ff_0f
// cycles that must never reach io_wr
2_0_0_0_41_77
3_0_0_0_42_66
4_0_0_0_43_55
2_0_0_0_3f_99
3_0_0_0_50_88
4_0_0_0_4e_44
// back to back writes at minimum spacing
5_1_1_0_44_01
5_1_1_0_45_02
5_1_0_0_90_03
1_1_1_0_44_04
5_1_1_0_4a_c3
5_1_1_0_4b_c4
5_1_1_0_4c_c5
1_1_1_0_4d_c6
// overwrite and a short strobe on a live register
1_1_1_0_4f_00
4_0_0_0_40_ee
1_1_1_0_41_12
0_0_0_0_00_00

//--- Makefile
# Verilator build and run of the Z80 I/O write path testbench
SIM     := verilator
FLAGS   := --binary --timing --assert -j 0
TOP     := z80_io_tb
FLIST   := flist.f
OBJ_DIR := obj_dir
PASS    := No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

# the run passes only when the pass line shows up in the simulator output
test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
+incdir+hdl
hdl/z80_io_pkg.sv
hdl/sync_stretch.sv
hdl/z80_io_cycle_fsm.sv
hdl/z80_wr_cdc.sv
hdl/z80_io_regs.sv
hdl/z80_io_top.sv
dv/z80_io_tb.sv
